// File: color_mapper_patterns.txt
// draw_x draw_y p1_x p1_y p2_x p2_y act1 act2 face1 face2 hp1 hp2 winner rgb addr1 addr2
// all hex, addr fffff means that address is not checked
06e 0fa 064 0c8 064 0c8 0 1 1 0 064 064 0 0000ff 06982 069e5
06e 0fa 064 0c8 064 0c8 2 3 0 1 064 064 0 000000 06a21 06a36
06e 0fa 064 0c8 064 0c8 4 5 1 0 064 064 0 0000ff 06a72 06ad5
06e 0fa 064 0c8 064 0c8 6 7 0 1 064 064 0 000000 06b11 06b26
06e 0fa 064 0c8 064 0c8 8 9 1 0 064 064 0 0000ff 06b62 13c99
06e 0fa 064 0c8 064 0c8 a b 0 1 064 064 0 000000 13c99 13cea
06e 0fa 064 0c8 064 0c8 c d 1 0 064 064 0 0000ff 13d26 13d89
06e 0fa 064 0c8 064 0c8 e f 0 1 064 064 0 000000 13dc5 13c72
070 0fa 064 0c8 064 0c8 0 0 1 1 064 064 0 ffffff 06984 06984
137 0fa 064 0c8 12c 0c8 0 0 1 1 064 064 0 0000ff fffff 06983
135 0fa 064 0c8 12c 0c8 0 0 1 0 064 064 0 ffffff fffff 069aa
09f 12b 064 0c8 12c 0c8 0 0 1 1 064 064 0 000000 0d10f fffff
09f 12b 064 0c8 12c 0c8 0 0 0 1 064 064 0 ffffff 0d0d4 fffff
0a0 12b 064 0c8 12c 0c8 0 0 1 1 064 064 0 ffffff fffff fffff
078 12c 064 0c8 12c 0c8 0 0 1 1 064 064 0 ffffff fffff fffff
033 014 064 0c8 12c 0c8 0 0 1 1 064 064 0 ff0000 fffff fffff
096 028 064 0c8 12c 0c8 0 0 1 1 064 064 0 ff0000 fffff fffff
097 01e 064 0c8 12c 0c8 0 0 1 1 064 064 0 ffffff fffff fffff
032 01e 064 0c8 12c 0c8 0 0 1 1 064 064 0 ffffff fffff fffff
1eb 028 064 0c8 12c 0c8 0 0 1 1 064 064 0 ff0000 fffff fffff
24e 014 064 0c8 12c 0c8 0 0 1 1 064 064 0 ff0000 fffff fffff
24f 014 064 0c8 12c 0c8 0 0 1 1 064 064 0 ffffff fffff fffff
064 029 064 0c8 12c 0c8 0 0 1 1 064 064 0 ffffff fffff fffff
064 013 064 0c8 12c 0c8 0 0 1 1 064 064 0 ffffff fffff fffff
1ef 01e 064 0c8 12c 0c8 0 0 1 1 064 005 0 ff0000 fffff fffff
1f0 01e 064 0c8 12c 0c8 0 0 1 1 064 005 0 ffffff fffff fffff
108 0e8 064 0c8 1f4 12c 0 0 1 1 064 064 1 0000ff fffff fffff
109 0e8 064 0c8 1f4 12c 0 0 1 1 064 064 1 000000 fffff fffff
14f 0eb 064 0c8 1f4 12c 0 0 1 1 064 064 2 0000ff fffff fffff
153 0f7 064 0c8 1f4 12c 0 0 1 1 064 064 1 0000ff fffff fffff
110 0e8 064 0c8 1f4 12c 0 0 1 1 064 064 1 000000 fffff fffff
108 0f8 064 0c8 1f4 12c 0 0 1 1 064 064 2 000000 fffff fffff
00a 00a 064 0c8 1f4 12c 0 0 1 1 064 064 2 000000 fffff fffff
06e 0fa 064 0c8 1f4 12c 0 0 1 1 064 064 1 000000 06982 fffff
183 0f0 064 0c8 1f4 12c 0 0 1 1 064 064 2 0000ff fffff fffff

// File: verilog.f
pixel_pkg.sv
sprite_addr_gen.sv
banner_font_addr.sv
color_compose.sv
color_mapper.sv
tb_rom_models.sv
tb_color_mapper.sv

// File: Makefile
# Verilator build, run and lint for the pixel colour pipeline
VERILATOR ?= verilator
TOP       ?= tb_color_mapper
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_color_mapper.sv
// pixel colour pipeline testbench
`timescale 1ns/1ps

module tb_color_mapper;

    localparam int          FIELDS    = 16;              // words per pattern line
    localparam int          MAX_PATS  = 64;
    localparam int          RESET_CYC = 4;
    localparam logic [31:0] NO_CHECK  = 32'hfffff;       // address column not checked

    logic                    Clk;
    logic                    rst_n;
    logic                    in_valid;
    logic                    in_ready;
    pixel_pkg::coord_t       draw_x, draw_y, p1_x, p1_y, p2_x, p2_y;
    pixel_pkg::action_e      action1, action2;
    pixel_pkg::facing_e      facing1, facing2;
    pixel_pkg::coord_t       health1, health2;
    pixel_pkg::winner_e      winner;
    logic                    out_valid;
    logic                    out_ready;
    logic [7:0]              vga_r, vga_g, vga_b;
    pixel_pkg::sprite_addr_t sprite_addr1, sprite_addr2;
    pixel_pkg::font_addr_t   font_addr;
    logic                    rom_en;
    pixel_pkg::rgb_t         sprite_data1, sprite_data2;
    logic [7:0]              font_data;

    logic [31:0]             pat_mem [0:FIELDS*MAX_PATS-1];
    int                      num_pats;
    pixel_pkg::rgb_t         exp_q [$];                  // accepted, not yet delivered
    logic [31:0]             lcg_state;
    logic                    s1_full;                    // expected stage occupancy
    logic                    s2_full;
    logic                    adv_exp;
    logic                    in_seen;

    color_mapper #(.SHEET_W(540), .FRAME_W(60), .FRAME_H(100)) dut0 (.*);
    tb_rom_models u_roms (.*);

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_rgb(input string name, input pixel_pkg::rgb_t got,
                               input pixel_pkg::rgb_t exp);
        if (got !== exp)
            stop_with_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_addr(input string name, input pixel_pkg::sprite_addr_t got,
                                input pixel_pkg::sprite_addr_t exp);
        if (got !== exp)
            stop_with_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] pattern_word(input int p, input int f);
        pattern_word = pat_mem[p*FIELDS + f];
    endfunction

    task automatic drive_pattern(input int p);
        draw_x   <= pixel_pkg::coord_t'(pattern_word(p, 0));
        draw_y   <= pixel_pkg::coord_t'(pattern_word(p, 1));
        p1_x     <= pixel_pkg::coord_t'(pattern_word(p, 2));
        p1_y     <= pixel_pkg::coord_t'(pattern_word(p, 3));
        p2_x     <= pixel_pkg::coord_t'(pattern_word(p, 4));
        p2_y     <= pixel_pkg::coord_t'(pattern_word(p, 5));
        action1  <= pixel_pkg::action_e'(4'(pattern_word(p, 6)));   // 10 and 15 pass as is
        action2  <= pixel_pkg::action_e'(4'(pattern_word(p, 7)));
        facing1  <= pixel_pkg::facing_e'(1'(pattern_word(p, 8)));
        facing2  <= pixel_pkg::facing_e'(1'(pattern_word(p, 9)));
        health1  <= pixel_pkg::coord_t'(pattern_word(p, 10));
        health2  <= pixel_pkg::coord_t'(pattern_word(p, 11));
        winner   <= pixel_pkg::winner_e'(2'(pattern_word(p, 12)));
        in_valid <= 1'b1;
    endtask

    // addresses sit in stage 1 from the accepting edge on
    task automatic check_addrs(input int p);
        if (pattern_word(p, 14) != NO_CHECK)
            compare_addr("sprite_addr1", sprite_addr1,
                         pixel_pkg::sprite_addr_t'(pattern_word(p, 14)));
        if (pattern_word(p, 15) != NO_CHECK)
            compare_addr("sprite_addr2", sprite_addr2,
                         pixel_pkg::sprite_addr_t'(pattern_word(p, 15)));
    endtask

    task automatic run_patterns();
        int   next_idx;
        int   check_idx;
        logic accepted;
        logic check_due;
        next_idx  = 0;
        check_idx = 0;
        check_due = 1'b0;
        @(posedge Clk);
        drive_pattern(0);
        while (next_idx < num_pats || check_due)
        begin
            @(negedge Clk);
            if (check_due)
            begin
                check_addrs(check_idx);
                check_due = 1'b0;
            end
            accepted = in_valid && in_ready;             // transfer on the coming edge
            @(posedge Clk);
            if (accepted)
            begin
                exp_q.push_back(pixel_pkg::rgb_t'(pattern_word(next_idx, 13)));
                check_idx = next_idx;
                check_due = 1'b1;
                next_idx++;
                if (next_idx < num_pats)
                    drive_pattern(next_idx);
                else
                    in_valid <= 1'b0;
            end
        end
    endtask

    // --------------------------------------------------
    // clock, back-pressure, monitor, watchdog
    // --------------------------------------------------
    initial
    begin
        Clk = 1'b0;
        forever
        begin
            #50 Clk = ~Clk;                              // 100 ns period
        end
    end

    initial
    begin
        lcg_state = 32'hca77c06f;
        out_ready = 1'b0;
        @(posedge rst_n);
        forever
        begin
            @(posedge Clk);
            lcg_state = lcg_next(lcg_state);
            out_ready <= (lcg_state[31:30] != 2'b00);    // ready about 3 cycles in 4
        end
    end

    // one stage per advancing edge, pipe moves when stage 2 empty or sink ready
    initial
    begin
        s1_full = 1'b0;
        s2_full = 1'b0;
        @(posedge rst_n);
        forever
        begin
            @(negedge Clk);
            adv_exp = !s2_full || out_ready;
            in_seen = in_valid;
            compare_flag("out_valid", out_valid, s2_full);
            compare_flag("in_ready", in_ready, adv_exp);
            compare_flag("rom_en", rom_en, adv_exp);
            @(posedge Clk);
            if (adv_exp)
            begin
                s2_full = s1_full;
                s1_full = in_seen;
            end
        end
    end

    // held output must match the oldest outstanding pixel
    initial
    begin
        @(posedge rst_n);
        forever
        begin
            @(negedge Clk);
            if (out_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    stop_with_error("output valid while no pixel was outstanding");
                end
                else
                begin
                    compare_rgb("vga_rgb", {vga_r, vga_g, vga_b}, exp_q[0]);
                    if (out_ready)
                        void'(exp_q.pop_front());
                end
            end
        end
    end

    initial
    begin
        @(posedge rst_n);
        repeat (num_pats * 20) @(posedge Clk);
        stop_with_error("timeout, not every pixel came out in time");
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial
    begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        draw_x   = '0;
        draw_y   = '0;
        p1_x     = '0;
        p1_y     = '0;
        p2_x     = '0;
        p2_y     = '0;
        action1  = pixel_pkg::ACT_STAND;
        action2  = pixel_pkg::ACT_STAND;
        facing1  = pixel_pkg::FACE_RIGHT;
        facing2  = pixel_pkg::FACE_RIGHT;
        health1  = '0;
        health2  = '0;
        winner   = pixel_pkg::NO_WINNER;
        foreach (pat_mem[i])
            pat_mem[i] = '1;                             // all ones marks end of data
        $readmemh("color_mapper_patterns.txt", pat_mem);
        num_pats = 0;
        while (num_pats < MAX_PATS && pat_mem[num_pats*FIELDS] != 32'hffffffff)
            num_pats++;
        if (num_pats == 0)
            stop_with_error("no patterns read from color_mapper_patterns.txt");
        repeat (RESET_CYC) @(posedge Clk);
        rst_n <= 1'b1;
        @(negedge Clk);
        compare_flag("out_valid", out_valid, 1'b0);      // empty pipe after reset
        compare_flag("in_ready", in_ready, 1'b1);
        run_patterns();
        while (exp_q.size() != 0)
            @(posedge Clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: tb_rom_models.sv
// behavioural sprite and font roms
`timescale 1ns/1ps

module tb_rom_models (
    input  logic                    Clk,
    input  logic                    rom_en,              // read strobe, outputs hold when low
    input  pixel_pkg::sprite_addr_t sprite_addr1,
    input  pixel_pkg::sprite_addr_t sprite_addr2,
    input  pixel_pkg::font_addr_t   font_addr,
    output pixel_pkg::rgb_t         sprite_data1,
    output pixel_pkg::rgb_t         sprite_data2,
    output logic [7:0]              font_data
);

    // even words transparent, odd words opaque and never the key
    function automatic pixel_pkg::rgb_t sprite_word(input pixel_pkg::sprite_addr_t a);
        if (a[0] == 1'b0)
        begin
            sprite_word = pixel_pkg::COLOR_KEY;
        end
        else
        begin
            sprite_word = 24'h123456 ^ {5'b0, a};        // top byte stays 0x1x
        end
    endfunction

    function automatic logic [7:0] font_word(input pixel_pkg::font_addr_t a);
        font_word = a[7:0] ^ a[10:3];                    // char code folded into the row
    endfunction

    always_ff @(posedge Clk)
    begin
        if (rom_en)
        begin
            sprite_data1 <= sprite_word(sprite_addr1);
            sprite_data2 <= sprite_word(sprite_addr2);
            font_data    <= font_word(font_addr);
        end
    end

endmodule

// File: color_mapper.sv
// two stage pixel colour pipeline
`timescale 1ns/1ps

module color_mapper #(
    parameter int SHEET_W = 540,
    parameter int FRAME_W = 60,
    parameter int FRAME_H = 100
) (
    input  logic                    Clk,
    input  logic                    rst_n,
    // pixel in
    input  logic                    in_valid,
    output logic                    in_ready,
    input  pixel_pkg::coord_t       draw_x,
    input  pixel_pkg::coord_t       draw_y,
    input  pixel_pkg::coord_t       p1_x,
    input  pixel_pkg::coord_t       p1_y,
    input  pixel_pkg::coord_t       p2_x,
    input  pixel_pkg::coord_t       p2_y,
    input  pixel_pkg::action_e      action1,
    input  pixel_pkg::action_e      action2,
    input  pixel_pkg::facing_e      facing1,
    input  pixel_pkg::facing_e      facing2,
    input  pixel_pkg::coord_t       health1,
    input  pixel_pkg::coord_t       health2,
    input  pixel_pkg::winner_e      winner,
    // rgb out
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [7:0]              vga_r,
    output logic [7:0]              vga_g,
    output logic [7:0]              vga_b,
    // sync rom side, data one cycle after rom_en edge
    output pixel_pkg::sprite_addr_t sprite_addr1,
    output pixel_pkg::sprite_addr_t sprite_addr2,
    output pixel_pkg::font_addr_t   font_addr,
    output logic                    rom_en,
    input  pixel_pkg::rgb_t         sprite_data1,
    input  pixel_pkg::rgb_t         sprite_data2,
    input  logic [7:0]              font_data
);

    logic                    advance;                    // both stages move
    logic                    s1_valid;
    logic                    s2_valid;
    // comb results of the incoming pixel
    logic                    hit1_c;
    logic                    hit2_c;
    pixel_pkg::sprite_addr_t addr1_c;
    pixel_pkg::sprite_addr_t addr2_c;
    logic                    in_cell_c;
    pixel_pkg::font_addr_t   font_addr_c;
    logic [2:0]              glyph_col_c;
    logic                    bar_hit_c;
    logic                    bar1_x_ok;
    logic                    bar2_x_ok;
    // stage flags
    logic                    s1_hit1, s1_hit2, s1_in_cell, s1_bar_hit;
    logic [2:0]              s1_glyph_col;
    pixel_pkg::winner_e      s1_winner;
    logic                    s2_hit1, s2_hit2, s2_in_cell, s2_bar_hit;
    logic [2:0]              s2_glyph_col;
    pixel_pkg::winner_e      s2_winner;
    pixel_pkg::rgb_t         color;

    assign advance   = !s2_valid || out_ready;
    assign in_ready  = advance;
    assign rom_en    = advance;                          // roms freeze with the pipe
    assign out_valid = s2_valid;

    // --------------------------------------------------
    // stage 1 address generation
    // --------------------------------------------------
    sprite_addr_gen #(.SHEET_W(SHEET_W), .FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_sprite1 (
        .draw_x(draw_x), .draw_y(draw_y), .pos_x(p1_x), .pos_y(p1_y),
        .action(action1), .facing(facing1), .hit(hit1_c), .addr(addr1_c)
    );

    sprite_addr_gen #(.SHEET_W(SHEET_W), .FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_sprite2 (
        .draw_x(draw_x), .draw_y(draw_y), .pos_x(p2_x), .pos_y(p2_y),
        .action(action2), .facing(facing2), .hit(hit2_c), .addr(addr2_c)
    );

    banner_font_addr u_banner (
        .draw_x(draw_x), .draw_y(draw_y), .winner(winner),
        .in_cell(in_cell_c), .font_addr(font_addr_c), .glyph_col(glyph_col_c)
    );

    // 11 bit sums so a long bar cannot wrap
    assign bar1_x_ok = (draw_x > pixel_pkg::BAR1_X) &&
                       ({1'b0, draw_x} <= {1'b0, pixel_pkg::BAR1_X} + {1'b0, health1});
    assign bar2_x_ok = (draw_x > pixel_pkg::BAR2_X) &&
                       ({1'b0, draw_x} <= {1'b0, pixel_pkg::BAR2_X} + {1'b0, health2});
    assign bar_hit_c = (draw_y >= pixel_pkg::BAR_Y_TOP) && (draw_y <= pixel_pkg::BAR_Y_BOT) &&
                       (bar1_x_ok || bar2_x_ok);

    // valid bits only
    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else if (advance)
        begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (advance && in_valid)                         // transfer edge
        begin
            sprite_addr1 <= addr1_c;
            sprite_addr2 <= addr2_c;
            font_addr    <= font_addr_c;
            s1_hit1      <= hit1_c;
            s1_hit2      <= hit2_c;
            s1_in_cell   <= in_cell_c;
            s1_glyph_col <= glyph_col_c;
            s1_winner    <= winner;
            s1_bar_hit   <= bar_hit_c;
        end
    end

    // --------------------------------------------------
    // stage 2, lines up with rom data
    // --------------------------------------------------
    always_ff @(posedge Clk)
    begin
        if (advance && s1_valid)
        begin
            s2_hit1      <= s1_hit1;
            s2_hit2      <= s1_hit2;
            s2_in_cell   <= s1_in_cell;
            s2_glyph_col <= s1_glyph_col;
            s2_winner    <= s1_winner;
            s2_bar_hit   <= s1_bar_hit;
        end
    end

    color_compose u_compose (
        .winner(s2_winner), .in_cell(s2_in_cell), .glyph_col(s2_glyph_col),
        .font_data(font_data), .hit1(s2_hit1), .hit2(s2_hit2),
        .sprite_data1(sprite_data1), .sprite_data2(sprite_data2),
        .bar_hit(s2_bar_hit), .color(color)
    );

    assign vga_r = color[23:16];
    assign vga_g = color[15:8];
    assign vga_b = color[7:0];

    // stalled output holds, rom outputs included
    assert property (@(posedge Clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable({vga_r, vga_g, vga_b}))
        else $error("rgb changed under back-pressure");

    // roms keep their last read while the pipe is frozen
    assert property (@(posedge Clk) disable iff (!rst_n)
        !rom_en |=> $stable({sprite_data1, sprite_data2, font_data}))
        else $error("rom data changed while rom_en was low");

endmodule

// File: color_compose.sv
// output colour priority select
`timescale 1ns/1ps

module color_compose (
    input  pixel_pkg::winner_e winner,
    input  logic               in_cell,                  // banner glyph cell
    input  logic [2:0]         glyph_col,
    input  logic [7:0]         font_data,                // msb is leftmost glyph px
    input  logic               hit1,
    input  logic               hit2,
    input  pixel_pkg::rgb_t    sprite_data1,
    input  pixel_pkg::rgb_t    sprite_data2,
    input  logic               bar_hit,                  // either health bar
    output pixel_pkg::rgb_t    color
);

    logic glyph_on;                                      // font bit under this pixel
    logic opaque1;
    logic opaque2;

    assign glyph_on = in_cell && font_data[3'd7 - glyph_col];
    assign opaque1  = (sprite_data1 != pixel_pkg::COLOR_KEY);
    assign opaque2  = (sprite_data2 != pixel_pkg::COLOR_KEY);

    // --------------------------------------------------
    // banner > p1 > p2 > bars > background
    // --------------------------------------------------
    always_comb
    begin
        if (winner != pixel_pkg::NO_WINNER)
        begin
            color = glyph_on ? pixel_pkg::COLOR_BLUE     // text on black screen
                             : pixel_pkg::COLOR_BLACK;
        end
        else if (hit1)
        begin
            if (opaque1)
            begin
                color = pixel_pkg::COLOR_BLACK;          // p1 drawn black
            end
            else if (hit2 && opaque2)
            begin
                color = pixel_pkg::COLOR_BLUE;           // p2 shows through p1 key
            end
            else
            begin
                color = pixel_pkg::COLOR_WHITE;
            end
        end
        else if (hit2)
        begin
            color = opaque2 ? pixel_pkg::COLOR_BLUE      // p2 drawn blue
                            : pixel_pkg::COLOR_WHITE;
        end
        else if (bar_hit)
        begin
            color = pixel_pkg::COLOR_RED;
        end
        else
        begin
            color = pixel_pkg::COLOR_WHITE;              // background
        end
    end

endmodule

// File: banner_font_addr.sv
// win banner font address
`timescale 1ns/1ps

module banner_font_addr (
    input  pixel_pkg::coord_t     draw_x,
    input  pixel_pkg::coord_t     draw_y,
    input  pixel_pkg::winner_e    winner,
    output logic                  in_cell,               // pixel on a glyph cell
    output pixel_pkg::font_addr_t font_addr,
    output logic [2:0]            glyph_col              // column inside the cell
);

    localparam int DIGIT_CELL = 7;                       // "0" replaced by winner

    logic              row_ok;                           // inside banner rows
    logic              found;
    logic [3:0]        cell_idx;
    pixel_pkg::coord_t cell_x;                           // left edge of cell under test
    pixel_pkg::coord_t col_off;
    pixel_pkg::coord_t row_off;
    logic [7:0]        char_code;

    assign row_off = draw_y - pixel_pkg::BANNER_Y;
    assign row_ok  = (draw_y >= pixel_pkg::BANNER_Y) && (32'(row_off) < pixel_pkg::GLYPH_H);

    // --------------------------------------------------
    // cell search
    // --------------------------------------------------
    always_comb
    begin
        found    = 1'b0;
        cell_idx = 4'd0;
        col_off  = '0;
        cell_x   = pixel_pkg::BANNER_X;
        for (int i = 0; i < pixel_pkg::BANNER_LEN; i++)
        begin
            cell_x = pixel_pkg::coord_t'(pixel_pkg::BANNER_X + i * pixel_pkg::CELL_PITCH);
            if ((draw_x >= cell_x) && (32'(draw_x) < 32'(cell_x) + pixel_pkg::GLYPH_W))
            begin
                found    = 1'b1;
                cell_idx = 4'(i);
                col_off  = draw_x - cell_x;              // per cell, not from cell 0
            end
        end
    end

    // ascii '0' + 1 or 2 gives the winning player digit
    always_comb
    begin
        char_code = pixel_pkg::BANNER_TEXT[cell_idx];
        if (cell_idx == 4'(DIGIT_CELL))
        begin
            char_code = pixel_pkg::BANNER_TEXT[DIGIT_CELL] + 8'(winner);
        end
    end

    assign in_cell   = (winner != pixel_pkg::NO_WINNER) && row_ok && found;
    assign font_addr = in_cell ? {char_code[6:0], row_off[3:0]} : '0;   // code*16 + row
    assign glyph_col = col_off[2:0];

endmodule

// File: sprite_addr_gen.sv
// sprite hit and sheet address
`timescale 1ns/1ps

module sprite_addr_gen #(
    parameter int SHEET_W = 540,                         // sheet width in pixels
    parameter int FRAME_W = 60,
    parameter int FRAME_H = 100
) (
    input  pixel_pkg::coord_t       draw_x,
    input  pixel_pkg::coord_t       draw_y,
    input  pixel_pkg::coord_t       pos_x,               // frame top left
    input  pixel_pkg::coord_t       pos_y,
    input  pixel_pkg::action_e      action,
    input  pixel_pkg::facing_e      facing,
    output logic                    hit,
    output pixel_pkg::sprite_addr_t addr
);

    pixel_pkg::coord_t       dx;                         // offset inside frame
    pixel_pkg::coord_t       dy;
    pixel_pkg::coord_t       col;                        // after mirroring
    logic [3:0]              frame_col;                  // frame index in its row
    logic                    frame_row;                  // 0 walk row, 1 stand/punch row
    pixel_pkg::sprite_addr_t base;

    assign dx  = draw_x - pos_x;                         // wraps when left of frame
    assign dy  = draw_y - pos_y;
    assign hit = (draw_x >= pos_x) && (32'(dx) < FRAME_W) &&
                 (draw_y >= pos_y) && (32'(dy) < FRAME_H);

    // --------------------------------------------------
    // frame selection
    // --------------------------------------------------
    always_comb
    begin
        frame_col = 4'd0;                                // standing frame
        frame_row = 1'b1;
        case (action)
            pixel_pkg::ACT_WALK0, pixel_pkg::ACT_WALK1, pixel_pkg::ACT_WALK2,
            pixel_pkg::ACT_WALK3, pixel_pkg::ACT_WALK4, pixel_pkg::ACT_WALK5,
            pixel_pkg::ACT_WALK6, pixel_pkg::ACT_WALK7, pixel_pkg::ACT_WALK8:
            begin
                frame_col = action;                      // code is the frame index
                frame_row = 1'b0;
            end
            pixel_pkg::ACT_PUNCH0, pixel_pkg::ACT_PUNCH1,
            pixel_pkg::ACT_PUNCH2, pixel_pkg::ACT_PUNCH3:
            begin
                frame_col = action - 4'd9;               // 11..14 -> 2..5
            end
            default:
            begin
                frame_col = 4'd0;                        // stand, also 10 and 15
            end
        endcase
    end

    assign col  = (facing == pixel_pkg::FACE_RIGHT) ? dx
                                                    : pixel_pkg::coord_t'(FRAME_W - 1) - dx;
    assign base = pixel_pkg::sprite_addr_t'(frame_col) * pixel_pkg::sprite_addr_t'(FRAME_W) +
                  (frame_row ? pixel_pkg::sprite_addr_t'(FRAME_H * SHEET_W) : '0);
    assign addr = base + pixel_pkg::sprite_addr_t'(dy) * pixel_pkg::sprite_addr_t'(SHEET_W) +
                  pixel_pkg::sprite_addr_t'(col);

    // frame table must fit the two sheet rows
    always_comb
    begin
        if (hit)
        begin
            assert final (32'(addr) < 2 * FRAME_H * SHEET_W)
                else $error("sprite address %h past sheet end", addr);
        end
    end

endmodule

// File: pixel_pkg.sv
// pixel colour stage definitions
package pixel_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    typedef logic [9:0]  coord_t;                        // screen coord or health length
    typedef logic [18:0] sprite_addr_t;                  // sprite sheet word address
    typedef logic [10:0] font_addr_t;                    // char code * 16 + glyph row
    typedef logic [23:0] rgb_t;                          // r in [23:16], b in [7:0]

    // animation codes, 10 and 15 unused and shown as standing
    typedef enum logic [3:0] {
        ACT_WALK0  = 4'd0,                               // row 0, frames 0..8
        ACT_WALK1  = 4'd1,
        ACT_WALK2  = 4'd2,
        ACT_WALK3  = 4'd3,
        ACT_WALK4  = 4'd4,
        ACT_WALK5  = 4'd5,
        ACT_WALK6  = 4'd6,
        ACT_WALK7  = 4'd7,
        ACT_WALK8  = 4'd8,
        ACT_STAND  = 4'd9,                               // row 1, col 0
        ACT_PUNCH0 = 4'd11,                              // row 1, cols 2..5
        ACT_PUNCH1 = 4'd12,
        ACT_PUNCH2 = 4'd13,
        ACT_PUNCH3 = 4'd14
    } action_e;

    typedef enum logic {
        FACE_LEFT  = 1'b0,                               // frame drawn mirrored
        FACE_RIGHT = 1'b1                                // frame as stored
    } facing_e;

    typedef enum logic [1:0] {
        NO_WINNER = 2'd0,
        P1_WINS   = 2'd1,
        P2_WINS   = 2'd2
    } winner_e;

    // --------------------------------------------------
    // colours
    // --------------------------------------------------
    localparam rgb_t COLOR_KEY   = 24'hff00ff;           // transparent sprite pixel
    localparam rgb_t COLOR_WHITE = 24'hffffff;
    localparam rgb_t COLOR_BLACK = 24'h000000;
    localparam rgb_t COLOR_BLUE  = 24'h0000ff;
    localparam rgb_t COLOR_RED   = 24'hff0000;

    // --------------------------------------------------
    // health bars and win banner
    // --------------------------------------------------
    localparam coord_t BAR_Y_TOP = 10'd20;               // inclusive
    localparam coord_t BAR_Y_BOT = 10'd40;               // inclusive
    localparam coord_t BAR1_X    = 10'd50;               // bar starts one px right of this
    localparam coord_t BAR2_X    = 10'd490;

    localparam coord_t BANNER_X   = 10'd264;             // left edge of cell 0
    localparam coord_t BANNER_Y   = 10'd232;             // top glyph row
    localparam int     GLYPH_W    = 8;
    localparam int     GLYPH_H    = 16;
    localparam int     CELL_PITCH = 10;                  // glyph plus 2 px gap
    localparam int     BANNER_LEN = 13;

    // "PLAYER 0 WINS", digit patched from winner
    localparam logic [0:BANNER_LEN-1][7:0] BANNER_TEXT = {
        8'h50, 8'h4c, 8'h41, 8'h59, 8'h45, 8'h52, 8'h20,
        8'h30, 8'h20, 8'h57, 8'h49, 8'h4e, 8'h53
    };

endpackage
